// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// ------------------------------------------------------------------------
	// basic types
	// ------------------------------------------------------------------------
	// one data or instruction word
	typedef logic [7:0] word_t;

	// ram covers 32 words, rom covers 16
	typedef logic [4:0] ram_addr_t;
	typedef logic [3:0] rom_addr_t;

	// ------------------------------------------------------------------------
	// sizes and constants
	// ------------------------------------------------------------------------
	localparam int RAM_WORDS = 32;
	localparam int ROM_WORDS = 16;

	// stores to this address show up at the top level
	localparam ram_addr_t WATCH_ADDR = 5'd31;

	// constant the boot program adds to the switches
	localparam word_t PROG_CONST = 8'h25;

	// extra cycles the access controller waits per access
	localparam int READ_CYCLES = 1;
	localparam int WRITE_CYCLES = 1;

	// opcode in instr[7:5], ram address operand in instr[4:0]
	typedef enum logic [2:0] {LDA = 3'd0, STA, ADD, IN, JMP, NOP} opcode_t;

	// cpu memory request, held while valid until ready
	typedef struct packed {
		logic valid;
		logic write;
		ram_addr_t addr;
		word_t data;
	} mem_req_t;

	// single ram port, shared by copy engine and access controller
	typedef struct packed {
		logic write;
		ram_addr_t addr;
		word_t data;
	} ram_port_t;

	// overall system phase
	typedef enum logic [1:0] {BOOT_RESET, BOOT_COPY, BOOT_RUN} boot_state_t;

endpackage

// ==== logic/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
	input  cpu_pkg::rom_addr_t addr,
	output cpu_pkg::word_t data
);

	// ------------------------------------------------------------------------
	// program table
	// ------------------------------------------------------------------------
	// loop: acc = switches + const, show it, then bump the counter at 13
	always_comb begin
		case (addr)
			// read switches into acc
			4'd0: data = {cpu_pkg::IN, 5'd0};
			// add the constant
			4'd1: data = {cpu_pkg::ADD, 5'd12};
			// store to the watched word
			4'd2: data = {cpu_pkg::STA, cpu_pkg::WATCH_ADDR};
			// loop counter, counter += step
			4'd3: data = {cpu_pkg::LDA, 5'd13};
			4'd4: data = {cpu_pkg::ADD, 5'd14};
			4'd5: data = {cpu_pkg::STA, 5'd13};
			// back to the start
			4'd6: data = {cpu_pkg::JMP, 5'd0};
			// data words
			4'd12: data = cpu_pkg::PROG_CONST;
			// counter start
			4'd13: data = 8'h00;
			// counter step
			4'd14: data = 8'h01;
			// unused slots
			default: data = {cpu_pkg::NOP, 5'd0};
		endcase
	end

endmodule

// ==== logic/boot_copy.sv ====
`timescale 1ns/1ps

module boot_copy (
	input  logic clock,
	input  logic reset,
	output cpu_pkg::rom_addr_t rom_addr,
	input  cpu_pkg::word_t rom_data,
	output cpu_pkg::ram_port_t port,
	output logic done
);

	// ------------------------------------------------------------------------
	// address walk
	// ------------------------------------------------------------------------
	cpu_pkg::rom_addr_t count;
	logic copied;
	logic last;

	// registered write port
	logic wr_en;
	cpu_pkg::ram_addr_t wr_addr;
	cpu_pkg::word_t wr_data;

	// rom is read combinationally at the counter
	assign rom_addr = count;
	assign last = (count == cpu_pkg::rom_addr_t'(cpu_pkg::ROM_WORDS - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			copied <= 1'b0;
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			// one word per cycle until the last one
			wr_en <= !copied;
			// done goes out together with the last write
			done <= !copied && last;
			if (!copied) begin
				count <= count + 4'd1;
				copied <= last;
			end
		end
	end

	// same address in ram as in rom
	always_ff @(posedge clock) begin
		wr_addr <= cpu_pkg::ram_addr_t'(count);
		wr_data <= rom_data;
	end

	assign port = '{write: wr_en, addr: wr_addr, data: wr_data};

	// idle after done until the next reset
	assert property (@(posedge clock) disable iff (reset)
		copied && !done |-> !port.write);

endmodule

// ==== logic/word_ram.sv ====
`timescale 1ns/1ps

module word_ram (
	input  logic clock,
	input  cpu_pkg::ram_port_t port,
	output cpu_pkg::word_t rdata
);

	// ------------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------------
	// contents only defined after the boot copy
	cpu_pkg::word_t mem [cpu_pkg::RAM_WORDS];

	// ------------------------------------------------------------------------
	// single port access
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		// write on enable
		if (port.write) begin
			mem[port.addr] <= port.data;
		end
		// read is always on, old word during a write
		rdata <= mem[port.addr];
	end

	// read data follows the address by one clock, as the
	// access controller and the cpu expect

endmodule

// ==== logic/acc_cpu.sv ====
`timescale 1ns/1ps

module acc_cpu (
	input  logic clock,
	input  logic reset,
	output cpu_pkg::mem_req_t req,
	input  logic mem_ready,
	input  cpu_pkg::word_t mem_rdata,
	input  cpu_pkg::word_t in_port
);

	// ------------------------------------------------------------------------
	// state and registers
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {FETCH, DECODE, LOAD, STORE, ADD_MEM} cpu_state_t;

	cpu_state_t state;
	cpu_pkg::ram_addr_t pc;
	// instruction register
	cpu_pkg::word_t ir;
	// accumulator
	cpu_pkg::word_t acc;

	// instruction fields
	cpu_pkg::opcode_t opcode;
	cpu_pkg::ram_addr_t operand;

	assign opcode = cpu_pkg::opcode_t'(ir[7:5]);
	assign operand = ir[4:0];

	// ------------------------------------------------------------------------
	// fetch / execute
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc <= '0;
			ir <= '0;
			acc <= '0;
			req <= '0;
		end else begin
			case (state)
				FETCH: begin
					// valid is low here, raise the instruction read
					if (!req.valid) begin
						req <= '{valid: 1'b1, write: 1'b0, addr: pc, data: acc};
					end else if (mem_ready) begin
						req.valid <= 1'b0;
						ir <= mem_rdata;
						pc <= pc + 5'd1;
						state <= DECODE;
					end
				end

				DECODE: begin
					case (opcode)
						cpu_pkg::LDA: begin
							req <= '{valid: 1'b1, write: 1'b0, addr: operand, data: acc};
							state <= LOAD;
						end
						cpu_pkg::STA: begin
							req <= '{valid: 1'b1, write: 1'b1, addr: operand, data: acc};
							state <= STORE;
						end
						cpu_pkg::ADD: begin
							req <= '{valid: 1'b1, write: 1'b0, addr: operand, data: acc};
							state <= ADD_MEM;
						end
						// no memory access for these
						cpu_pkg::IN: begin
							acc <= in_port;
							state <= FETCH;
						end
						cpu_pkg::JMP: begin
							pc <= operand;
							state <= FETCH;
						end
						default: begin
							state <= FETCH;
						end
					endcase
				end

				// memory operand states, each ends on mem_ready
				LOAD: begin
					if (mem_ready) begin
						acc <= mem_rdata;
						req.valid <= 1'b0;
						state <= FETCH;
					end
				end

				STORE: begin
					if (mem_ready) begin
						req.valid <= 1'b0;
						state <= FETCH;
					end
				end

				ADD_MEM: begin
					if (mem_ready) begin
						acc <= acc + mem_rdata;
						req.valid <= 1'b0;
						state <= FETCH;
					end
				end

				default: begin
					state <= FETCH;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// handshake checks
	// ------------------------------------------------------------------------
	// request held while waiting
	assert property (@(posedge clock) disable iff (reset)
		req.valid && !mem_ready |=> $stable(req));

	// valid drops right after ready
	assert property (@(posedge clock) disable iff (reset)
		req.valid && mem_ready |=> !req.valid);

endmodule

// ==== logic/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
	input  logic clock,
	input  logic reset,
	input  cpu_pkg::mem_req_t req,
	output logic mem_ready,
	output cpu_pkg::ram_port_t port,
	output logic watch_strobe,
	output cpu_pkg::word_t watch_data
);

	// ------------------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {MEM_WAIT, MEM_READY, MEM_PREPARE, MEM_WRITE} access_state_t;

	access_state_t state, next_state;
	logic [1:0] read_cycle, write_cycle;
	cpu_pkg::word_t write_data;
	logic watch_hit;

	// store to the watched word as seen in prepare
	assign watch_hit = (state == MEM_PREPARE) && (req.addr == cpu_pkg::WATCH_ADDR);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= MEM_WAIT;
			read_cycle <= '0;
			write_cycle <= '0;
			watch_strobe <= 1'b0;
		end else begin
			state <= next_state;
			watch_strobe <= watch_hit;
			// wait counters restart on each entry
			if (state != MEM_READY || read_cycle == 2'(cpu_pkg::READ_CYCLES))
				read_cycle <= '0;
			else
				read_cycle <= read_cycle + 2'd1;
			if (state != MEM_WRITE || write_cycle == 2'(cpu_pkg::WRITE_CYCLES))
				write_cycle <= '0;
			else
				write_cycle <= write_cycle + 2'd1;
		end
	end

	// write value and watched value
	always_ff @(posedge clock) begin
		if (state == MEM_PREPARE) begin
			write_data <= req.data;
			if (watch_hit)
				watch_data <= req.data;
		end
	end

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		mem_ready = 1'b0;
		case (state)
			MEM_WAIT: begin
				if (req.valid)
					next_state = req.write ? MEM_PREPARE : MEM_READY;
			end
			// read data from ram arrives with ready
			MEM_READY: begin
				if (read_cycle == 2'(cpu_pkg::READ_CYCLES)) begin
					mem_ready = 1'b1;
					next_state = MEM_WAIT;
				end
			end
			MEM_PREPARE: next_state = MEM_WRITE;
			MEM_WRITE: begin
				if (write_cycle == 2'(cpu_pkg::WRITE_CYCLES))
					next_state = MEM_READY;
			end
			default: next_state = MEM_WAIT;
		endcase
	end

	assign port = '{write: (state == MEM_WRITE), addr: req.addr, data: write_data};

	// the ram port uses the request live, so it stays put until ready
	assert property (@(posedge clock) disable iff (reset)
		state != MEM_WAIT |-> req.valid && $stable(req));

endmodule

// ==== logic/cpu_system.sv ====
`timescale 1ns/1ps

module cpu_system (
	input  logic clock,
	input  logic reset,
	input  cpu_pkg::word_t switches,
	output logic booting,
	output logic running,
	output logic watch_strobe,
	output cpu_pkg::word_t watch_data
);

	// ------------------------------------------------------------------------
	// boot state machine
	// ------------------------------------------------------------------------
	cpu_pkg::boot_state_t state, next_state;
	logic copy_reset, run_reset, copy_done;
	cpu_pkg::rom_addr_t rom_addr;
	cpu_pkg::word_t rom_data, ram_rdata;
	cpu_pkg::ram_port_t copy_port, access_port, ram_port;
	cpu_pkg::mem_req_t mem_req;
	logic mem_ready;

	always_ff @(posedge clock) begin
		if (reset)
			state <= cpu_pkg::BOOT_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_pkg::BOOT_RESET: next_state = cpu_pkg::BOOT_COPY;
			cpu_pkg::BOOT_COPY: if (copy_done) next_state = cpu_pkg::BOOT_RUN;
			default: next_state = state;
		endcase
	end

	// block resets, external reset acts at once
	assign copy_reset = reset || (state == cpu_pkg::BOOT_RESET);
	assign run_reset = reset || (state != cpu_pkg::BOOT_RUN);
	assign booting = (state != cpu_pkg::BOOT_RUN);
	assign running = (state == cpu_pkg::BOOT_RUN);

	// ram port owner follows the boot phase
	assign ram_port = running ? access_port : copy_port;

	// ------------------------------------------------------------------------
	// instances
	// ------------------------------------------------------------------------
	boot_rom rom_i (.addr(rom_addr), .data(rom_data));

	boot_copy copy_i (
		.clock(clock), .reset(copy_reset), .rom_addr(rom_addr),
		.rom_data(rom_data), .port(copy_port), .done(copy_done)
	);

	word_ram ram_i (.clock(clock), .port(ram_port), .rdata(ram_rdata));

	acc_cpu cpu_i (
		.clock(clock), .reset(run_reset), .req(mem_req), .mem_ready(mem_ready),
		.mem_rdata(ram_rdata), .in_port(switches)
	);

	mem_access access_i (
		.clock(clock), .reset(run_reset), .req(mem_req), .mem_ready(mem_ready),
		.port(access_port), .watch_strobe(watch_strobe), .watch_data(watch_data)
	);

	// cpu side never writes ram while booting
	assert property (@(posedge clock) disable iff (reset)
		!running |-> !access_port.write);

endmodule

// ==== tests/tb_cpu_system.sv ====
`timescale 1ns/1ps

module tb_cpu_system;

	// ------------------------------------------------------------------------
	// run sizes
	// ------------------------------------------------------------------------
	localparam int PERIOD_NS = 100;
	localparam int RESET_CYCLES = 10;
	// running rises on this rising edge after reset falls
	localparam int BOOT_EDGES = 18;
	localparam int RUNS = 2;
	localparam int STROBES = 100;
	// one pass of the seven instruction loop takes 56 cycles
	localparam int MAX_GAP = 64;
	// every strobe within MAX_GAP, plus slack for resets and boot
	localparam int WATCHDOG_CYCLES = RUNS * STROBES * MAX_GAP + 200;

	logic clock;
	logic reset;
	cpu_pkg::word_t switches;
	logic booting;
	logic running;
	logic watch_strobe;
	cpu_pkg::word_t watch_data;

	// error counts and model state
	int word_errors;
	int flag_errors;
	int other_errors;
	int strobe_count;
	int total_strobes;
	int gap;
	logic have_value;
	cpu_pkg::word_t held_value;

	cpu_system UUT (
		.clock(clock),
		.reset(reset),
		.switches(switches),
		.booting(booting),
		.running(running),
		.watch_strobe(watch_strobe),
		.watch_data(watch_data)
	);

	initial clock = 1'b0;
	always #(PERIOD_NS / 2) clock = ~clock;

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input cpu_pkg::word_t actual, input cpu_pkg::word_t expected,
			input string what);
		if (actual !== expected) begin
			word_errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			flag_errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	// ------------------------------------------------------------------------
	// reset and boot phase
	// ------------------------------------------------------------------------
	// called at time 0 or right after a falling edge
	task automatic apply_reset();
		reset = 1'b1;
		have_value = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_flag(booting, 1'b1, "booting during reset");
			check_flag(running, 1'b0, "running during reset");
			check_flag(watch_strobe, 1'b0, "watch_strobe during reset");
		end
		reset = 1'b0;
	endtask

	// one falling edge per rising edge since reset fell
	task automatic check_boot();
		for (int edge_n = 1; edge_n <= BOOT_EDGES; edge_n++) begin
			@(negedge clock);
			check_flag(running, edge_n == BOOT_EDGES, "running during boot");
			check_flag(booting, edge_n != BOOT_EDGES, "booting during boot");
			check_flag(watch_strobe, 1'b0, "watch_strobe during boot");
		end
		gap = 0;
	endtask

	// ------------------------------------------------------------------------
	// one clock of the running system
	// ------------------------------------------------------------------------
	task automatic watch_cycle();
		cpu_pkg::word_t expected;
		@(negedge clock);
		check_flag(running, 1'b1, "running");
		check_flag(booting, 1'b0, "booting");
		if (watch_strobe) begin
			// switches stable since the last strobe, so IN saw this value
			expected = switches + cpu_pkg::PROG_CONST;
			check_word(watch_data, expected, "watch_data at strobe");
			held_value = expected;
			have_value = 1'b1;
			strobe_count++;
			total_strobes++;
			gap = 0;
			// next value, well before the next IN
			switches = cpu_pkg::word_t'($urandom);
		end else begin
			gap++;
			if (have_value)
				check_word(watch_data, held_value, "watch_data between strobes");
			// report once per stall
			if (gap == MAX_GAP + 1) begin
				other_errors++;
				$display("no watch strobe for more than %0d cycles at %0t", MAX_GAP, $time);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int cut;
		void'($urandom(78));
		reset = 1'b1;
		switches = cpu_pkg::word_t'($urandom);
		word_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		strobe_count = 0;
		total_strobes = 0;
		gap = 0;
		have_value = 1'b0;
		held_value = '0;
		for (int run = 0; run < RUNS; run++) begin
			apply_reset();
			check_boot();
			strobe_count = 0;
			while (strobe_count < STROBES)
				watch_cycle();
			// keep going to a random point of the loop, next reset hits mid-run
			if (run < RUNS - 1) begin
				cut = $urandom_range(MAX_GAP, 1);
				repeat (cut) watch_cycle();
			end
		end
		$display("errors: %0d word, %0d flag, %0d other; %0d strobes checked",
			word_errors, flag_errors, other_errors, total_strobes);
		if (word_errors + flag_errors + other_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// hang guard
	initial begin
		#(WATCHDOG_CYCLES * PERIOD_NS);
		$display("watchdog expired after %0d clock cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb.f ====
logic/cpu_pkg.sv
logic/boot_rom.sv
logic/boot_copy.sv
logic/word_ram.sv
logic/acc_cpu.sv
logic/mem_access.sv
logic/cpu_system.sv
tests/tb_cpu_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_cpu_system --Mdir obj_dir -o tb_cpu_system > build.log 2>&1 \
	&& ./obj_dir/tb_cpu_system > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
